// ==== uartTx.f ====
logic/uartTxPkg.sv
logic/txFrameIf.sv
logic/baudGen.sv
logic/txFifo.sv
logic/txShifter.sv
logic/txControl.sv
logic/uartTx.sv
verif/tbUartTx.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module tbUartTx \
    -f uartTx.f -o simUartTx

out=$(./obj_dir/simUartTx)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== verif/tbUartTx.sv ====
`timescale 1ns/10ps

module tbUartTx;
    import uartTxPkg::*;

    localparam logic [15:0] BaudDiv     = 16'd2;
    localparam int          FifoDepth   = 8;
    localparam int          BitCycles   = 16 * int'(BaudDiv);   // Clk cycles per bit
    localparam int          TotalFrames = 6 + 16 + 4 + 8;       // Sum over all tests
    localparam int          TimeLimit   = (TotalFrames * 12 + 80) * BitCycles * 100;

    logic       Clk;
    logic       reset;
    logic       wrEn;
    logic [7:0] wrData;
    logic [3:0] fmtCode;
    logic       cts;
    logic       full;
    logic       txD;
    logic       txIdle;
    logic       txStart;
    logic       txShift;
    logic       txStop;

    logic [7:0]  expByteQ [$];   // Bytes accepted by the FIFO in order
    logic [3:0]  expCodeQ [$];   // Format code for each of them
    logic [11:0] rxQ [$];        // Frames seen on the line with the start bit in bit 0
    int          errCount = 0;
    int          rxCount  = 0;
    int          testNum  = 0;
    integer      seed     = 16;

    uartTx #(.BaudDiv(BaudDiv), .FifoDepth(FifoDepth)) i_uartTx (
        .Clk     (Clk),
        .reset   (reset),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .fmtCode (fmtCode),
        .cts     (cts),
        .full    (full),
        .txD     (txD),
        .txIdle  (txIdle),
        .txStart (txStart),
        .txShift (txShift),
        .txStop  (txStop)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model

    // Start, data, parity and stop bits of one frame
    function automatic logic [3:0] frameBits(input logic [3:0] code);
        fmtT        f;
        logic [3:0] n;
        f = decodeFmt(code);
        n = 4'd10;                           // 8N1
        if (f.len)     n = n - 4'd1;
        if (f.parEn)   n = n + 4'd1;
        if (f.numStop) n = n + 4'd1;
        return n;
    endfunction

    function automatic logic [11:0] expectFrame(input logic [7:0] b, input logic [3:0] code);
        fmtT         f;
        logic [11:0] fr;
        logic [7:0]  d;
        logic [3:0]  pos;
        int          nData;
        int          ones;
        f     = decodeFmt(code);
        nData = f.len ? 7 : 8;               // Bit 7 never sent in 7-bit formats
        fr    = '0;                          // Start bit low
        d     = b;
        ones  = 0;
        pos   = 4'd1;
        for (int i = 0; i < nData; i++) begin
            fr[pos] = d[0];                  // LSB first
            if (d[0]) ones++;
            d   = d >> 1;
            pos = pos + 4'd1;
        end
        if (f.parEn) begin
            case (f.par)
                ParOdd:   fr[pos] = (ones % 2 == 0);   // Make total odd
                ParEven:  fr[pos] = (ones % 2 != 0);
                ParSpace: fr[pos] = 1'b0;
                default:  fr[pos] = 1'b1;
            endcase
            pos = pos + 4'd1;
        end
        fr[pos] = 1'b1;
        if (f.numStop) fr[pos + 4'd1] = 1'b1;
        return fr;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Line monitor and frame compare

    initial begin : lineMonitor
        logic [11:0] rx;
        logic [3:0]  nBits;
        logic [3:0]  nData;
        logic [3:0]  idx;
        fmtT         f;
        wait (reset === 1'b0);
        forever begin
            @(negedge txD);                  // Start bit edge
            f     = decodeFmt(fmtCode);
            nBits = frameBits(fmtCode);
            nData = f.len ? 4'd7 : 4'd8;
            rx    = '0;
            repeat (BitCycles / 2) @(negedge Clk);
            for (idx = 4'd0; idx < nBits; idx = idx + 4'd1) begin
                rx[idx] = txD;               // Mid-bit sample
                compareStatus(idx, nData, f.parEn);
                if (idx != nBits - 4'd1) repeat (BitCycles) @(negedge Clk);
            end
            rxQ.push_back(rx);
        end
    end

    initial begin : compareFrames
        logic [11:0] rx;
        logic [11:0] expFrame;
        logic [7:0]  b;
        logic [3:0]  code;
        forever begin
            @(negedge Clk);
            while (rxQ.size() > 0) begin
                rx = rxQ.pop_front();
                rxCount++;
                if (expByteQ.size() == 0) begin
                    $display("Unexpected frame 0x%03h seen on txD", rx);
                    errCount++;
                end else begin
                    b        = expByteQ.pop_front();
                    code     = expCodeQ.pop_front();
                    expFrame = expectFrame(b, code);
                    if (rx !== expFrame) begin
                        $display("Error: txD 0x%03h, expected 0x%03h (byte 0x%02h, code 0x%h)",
                                 rx, expFrame, b, code);
                        errCount++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(TimeLimit);
        $display("Timeout: frames still missing after %0d ns", TimeLimit);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic writeByte(input logic [7:0] b);
        @(negedge Clk);
        wrEn   = 1'b1;
        wrData = b;
        @(negedge Clk);
        wrEn   = 1'b0;
    endtask

    // Write and expect it on the line
    task automatic queueByte(input logic [7:0] b);
        expByteQ.push_back(b);
        expCodeQ.push_back(fmtCode);
        writeByte(b);
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            errCount++;
        end
    endtask

    // Status outputs expected in the middle of line bit pos
    task automatic compareStatus(input logic [3:0] pos, input logic [3:0] nData,
                                 input logic parEn);
        logic inData;
        logic inStop;
        inData = (pos != 4'd0) && (pos <= nData);
        inStop = (pos > nData + {3'd0, parEn});   // Parity bit shows no status
        checkLevel("txIdle", txIdle, 1'b0);
        checkLevel("txStart", txStart, pos == 4'd0);
        checkLevel("txShift", txShift, inData);
        checkLevel("txStop", txStop, inStop);
    endtask

    // Until every expected frame arrived and the line is idle again
    task automatic waitDrain();
        while (expByteQ.size() != 0) @(negedge Clk);
        while (txIdle !== 1'b1) @(negedge Clk);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testNum++;
        $display("Test %0d %s: %s", testNum, name, (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests

    initial begin : mainSeq
        int   errBefore;
        int   rxBefore;
        logic gapSeen;
        logic [7:0] b;
        reset   = 1'b1;
        wrEn    = 1'b0;
        wrData  = 8'h00;
        fmtCode = 4'h0;
        cts     = 1'b1;
        repeat (10) @(negedge Clk);
        reset = 1'b0;

        errBefore = errCount;        // Idle levels with empty FIFO
        repeat (10 * BitCycles) begin
            @(negedge Clk);
            checkLevel("txD", txD, 1'b1);
            checkLevel("txIdle", txIdle, 1'b1);
            checkLevel("txStart", txStart, 1'b0);
            checkLevel("txShift", txShift, 1'b0);
            checkLevel("txStop", txStop, 1'b0);
            checkLevel("full", full, 1'b0);
        end
        reportTest("reset and idle", errBefore);

        errBefore = errCount;        // 8N1 random bytes
        repeat (6) queueByte(8'($random(seed)));
        waitDrain();
        reportTest("8N1 bytes", errBefore);

        errBefore = errCount;        // One byte in each format
        for (int c = 0; c < 16; c++) begin
            @(negedge Clk);
            fmtCode = 4'(c);
            queueByte(8'($random(seed)) | 8'h80);   // Bit 7 set so 7-bit codes must drop it
            waitDrain();
        end
        fmtCode = 4'h0;
        reportTest("all formats", errBefore);

        errBefore = errCount;        // cts hold-off
        cts = 1'b0;
        repeat (4) queueByte(8'($random(seed)));
        gapSeen = 1'b0;
        repeat (20 * BitCycles) begin
            @(negedge Clk);
            if (txD !== 1'b1 || txIdle !== 1'b1) gapSeen = 1'b1;
        end
        if (gapSeen) begin
            $display("Start bit sent while cts was low");
            errCount++;
        end
        @(negedge Clk);
        cts = 1'b1;
        waitDrain();
        reportTest("cts hold-off", errBefore);

        errBefore = errCount;        // Overfill then drain back to back
        @(negedge Clk);
        cts = 1'b0;
        for (int i = 0; i < 10; i++) begin
            b = 8'($random(seed));
            if (i < FifoDepth) queueByte(b);
            else writeByte(b);                       // Dropped by the full FIFO
            if (i == FifoDepth - 2) checkLevel("full", full, 1'b0);
            if (i >= FifoDepth - 1) checkLevel("full", full, 1'b1);
        end
        cts = 1'b1;
        while (txIdle === 1'b1) @(negedge Clk);
        gapSeen = 1'b0;
        while (expByteQ.size() != 0) begin
            @(negedge Clk);
            if (txIdle !== 1'b0) gapSeen = 1'b1;    // Idle between burst frames
        end
        if (gapSeen) begin
            $display("Idle gap seen between burst frames");
            errCount++;
        end
        waitDrain();
        rxBefore = rxCount;
        repeat (24 * BitCycles) @(negedge Clk);
        if (rxCount != rxBefore || txIdle !== 1'b1) begin
            $display("Line did not stay idle after the burst");
            errCount++;
        end
        reportTest("full FIFO burst", errBefore);

        $display("Frames checked %0d, errors %0d", rxCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== logic/uartTx.sv ====
`timescale 1ns/10ps

module uartTx #(
    parameter logic [15:0] BaudDiv   = 16'd2,   // Clk cycles per 16x enable
    parameter int          FifoDepth = 8        // Transmit FIFO entries
) (
    input  logic       Clk,
    input  logic       reset,
    input  logic       wrEn,
    input  logic [7:0] wrData,
    input  logic [3:0] fmtCode,
    input  logic       cts,
    output logic       full,
    output logic       txD,
    output logic       txIdle,
    output logic       txStart,
    output logic       txShift,
    output logic       txStop
);

    logic       ce16x;
    logic       rdEn;
    logic [7:0] rdData;
    logic       empty;

    txFrameIf frame ();    // Controller to shifter

    baudGen #(.BaudDiv(BaudDiv)) i_baudGen (
        .Clk   (Clk),
        .reset (reset),
        .ce16x (ce16x)
    );

    txFifo #(.FifoDepth(FifoDepth)) i_txFifo (
        .Clk    (Clk),
        .reset  (reset),
        .wrEn   (wrEn),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdData (rdData),
        .empty  (empty),
        .full   (full)
    );

    txControl i_txControl (
        .Clk     (Clk),
        .reset   (reset),
        .ce16x   (ce16x),
        .fmtCode (fmtCode),
        .cts     (cts),
        .empty   (empty),
        .rdData  (rdData),
        .rdEn    (rdEn),
        .frame   (frame.control),
        .txIdle  (txIdle),
        .txStart (txStart),
        .txShift (txShift),
        .txStop  (txStop)
    );

    txShifter i_txShifter (
        .Clk   (Clk),
        .reset (reset),
        .frame (frame.shifter),
        .txD   (txD)
    );

endmodule

// ==== logic/txControl.sv ====
`timescale 1ns/10ps

module txControl (
    input  logic       Clk,
    input  logic       reset,
    input  logic       ce16x,
    input  logic [3:0] fmtCode,
    input  logic       cts,
    input  logic       empty,
    input  logic [7:0] rdData,
    output logic       rdEn,
    txFrameIf.control  frame,
    output logic       txIdle,
    output logic       txStart,
    output logic       txShift,
    output logic       txStop
);
    import uartTxPkg::*;

    txStateT    state;
    fmtT        curFmt;     // Live decode of fmtCode
    fmtT        fmtLat;     // Format of the frame in flight
    logic [3:0] tickCnt;    // 16x enables within a bit
    logic [2:0] bitCnt;     // Data bit index
    logic       stopCnt;    // Stop bit index
    logic       bitEnd;
    logic       lastData;
    logic       lastStop;
    logic       startFrame;

    assign curFmt = decodeFmt(fmtCode);

    ////////////////////////////////////////////////////////////////////
    // Bit timing and frame start

    assign bitEnd   = ce16x && (tickCnt == 4'd15);              // 16th enable of a bit
    assign lastData = (bitCnt == (fmtLat.len ? 3'd6 : 3'd7));
    assign lastStop = (stopCnt == fmtLat.numStop);

    // New frame from Idle, or straight after the final stop bit
    assign startFrame = ce16x && cts && !empty &&
                        ((state == Idle) || ((state == Stop) && bitEnd && lastStop));

    assign rdEn        = startFrame;          // Pop together with load
    assign frame.load  = startFrame;
    assign frame.shift = bitEnd && (state != Idle);
    assign frame.data  = rdData;
    assign frame.fmt   = curFmt;              // Shifter samples it at load
    assign frame.state = state;

    always_ff @(posedge Clk) begin
        if (reset) begin
            tickCnt <= 4'd0;
        end else if (state == Idle) begin
            tickCnt <= 4'd0;                  // Load enable is tick 0
        end else if (ce16x) begin
            tickCnt <= tickCnt + 4'd1;        // Wraps at each bit end
        end
    end

    // Format held for the whole frame
    always_ff @(posedge Clk) begin
        if (startFrame) begin
            fmtLat <= curFmt;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge Clk) begin
        if (reset) begin
            state   <= Idle;
            bitCnt  <= 3'd0;
            stopCnt <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (startFrame) begin
                        state <= Start;
                    end
                end
                Start: begin
                    if (bitEnd) begin
                        state  <= Shift;
                        bitCnt <= 3'd0;
                    end
                end
                Shift: begin
                    if (bitEnd && lastData) begin
                        state   <= fmtLat.parEn ? Parity : Stop;
                        stopCnt <= 1'b0;
                    end else if (bitEnd) begin
                        bitCnt <= bitCnt + 3'd1;
                    end
                end
                Parity: begin
                    if (bitEnd) begin
                        state <= Stop;
                    end
                end
                Stop: begin
                    if (bitEnd && lastStop) begin
                        state <= startFrame ? Start : Idle;   // Back to back when data waits
                    end else if (bitEnd) begin
                        stopCnt <= 1'b1;                      // Second stop bit
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Status decodes
    assign txIdle  = (state == Idle);
    assign txStart = (state == Start);
    assign txShift = (state == Shift);
    assign txStop  = (state == Stop);

    ////////////////////////////////////////////////////////////////////
    // Checks

    // Pop only a byte the FIFO actually holds
    assert property (@(posedge Clk) disable iff (reset) rdEn |-> !empty)
    else $error("txControl: rdEn with FIFO empty");

    // Parity state reached only for a parity format latched at load
    assert property (@(posedge Clk) disable iff (reset)
        (state != Parity) |=> ((state != Parity) || fmtLat.parEn))
    else $error("txControl: Parity state without parity enabled");

endmodule

// ==== logic/txShifter.sv ====
`timescale 1ns/10ps

module txShifter (
    input  logic Clk,
    input  logic reset,
    txFrameIf.shifter frame,
    output logic txD
);
    import uartTxPkg::*;

    logic [8:0] shiftReg;   // Start bit in bit 0, byte above it
    logic [7:0] parData;    // Bits that take part in parity
    logic       parReg;
    logic       txNext;

    // Bit 7 is not sent in 7-bit formats
    assign parData = frame.fmt.len ? {1'b0, frame.data[6:0]} : frame.data;

    ////////////////////////////////////////////////////////////////////
    // Frame register

    always_ff @(posedge Clk) begin
        if (frame.load) begin
            shiftReg <= {frame.data, 1'b0};          // Low start bit goes out first
            case (frame.fmt.par)
                ParOdd:   parReg <= ~^parData;       // Total ones odd
                ParEven:  parReg <= ^parData;        // Total ones even
                ParSpace: parReg <= 1'b0;
                default:  parReg <= 1'b1;            // Mark
            endcase
        end else if (frame.shift) begin
            shiftReg <= {1'b1, shiftReg[8:1]};       // LSB first
        end
    end

    assign frame.parBit = parReg;

    // Line level by FSM state
    always_comb begin
        case (frame.state)
            Start,
            Shift:   txNext = shiftReg[0];
            Parity:  txNext = parReg;
            default: txNext = 1'b1;                  // Stop and Idle are marking
        endcase
    end

    // Output flop keeps the line free of decode glitches
    always_ff @(posedge Clk) begin
        if (reset) begin
            txD <= 1'b1;
        end else begin
            txD <= txNext;
        end
    end

endmodule

// ==== logic/txFifo.sv ====
`timescale 1ns/10ps

module txFifo #(
    parameter int FifoDepth = 8    // Entries, power of two
) (
    input  logic       Clk,
    input  logic       reset,
    input  logic       wrEn,
    input  logic [7:0] wrData,
    input  logic       rdEn,
    output logic [7:0] rdData,
    output logic       empty,
    output logic       full
);

    localparam int AddrW = $clog2(FifoDepth);
    localparam int PtrW  = AddrW + 1;     // Extra wrap bit

    logic [7:0]      mem [FifoDepth];     // Byte storage
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] fillLevel;           // Entries in use
    logic            wrOk;
    logic            rdOk;

    assign wrOk = wrEn && !full;          // Writes while full are lost
    assign rdOk = rdEn && !empty;         // Reads while empty ignored

    ////////////////////////////////////////////////////////////////////
    // Pointers

    always_ff @(posedge Clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Storage write
    always_ff @(posedge Clk) begin
        if (wrOk) begin
            mem[wrPtr[AddrW-1:0]] <= wrData;
        end
    end

    assign rdData = mem[rdPtr[AddrW-1:0]];     // Head of queue while not empty

    // Wrap bits tell full from empty at equal addresses
    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]) &&
                   (wrPtr[AddrW] != rdPtr[AddrW]);

    assign fillLevel = wrPtr - rdPtr;

    ////////////////////////////////////////////////////////////////////
    // Checks

    assert property (@(posedge Clk) disable iff (reset) rdEn |-> !empty)
    else $error("txFifo: read strobe while empty");

    // Pointer spread can never exceed the storage
    assert property (@(posedge Clk) disable iff (reset)
        fillLevel <= PtrW'(FifoDepth))
    else $error("txFifo: pointer distance %0d beyond depth", fillLevel);

endmodule

// ==== logic/baudGen.sv ====
`timescale 1ns/10ps

module baudGen #(
    parameter logic [15:0] BaudDiv = 16'd2    // Clk cycles per 16x enable
) (
    input  logic Clk,
    input  logic reset,
    output logic ce16x
);

    logic [15:0] divCnt;   // Free running divider
    logic        divWrap;

    assign divWrap = (divCnt == (BaudDiv - 16'd1));

    always_ff @(posedge Clk) begin
        if (reset) begin
            divCnt <= 16'd0;
        end else if (divWrap) begin
            divCnt <= 16'd0;             // Restart period
        end else begin
            divCnt <= divCnt + 16'd1;
        end
    end

    // Registered enable, one Clk wide on each wrap
    always_ff @(posedge Clk) begin
        if (reset) begin
            ce16x <= 1'b0;
        end else begin
            ce16x <= divWrap;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks

    // Enable must stay a single-cycle pulse for any real divide
    assert property (@(posedge Clk) disable iff (reset)
        ((BaudDiv > 16'd1) && ce16x) |=> !ce16x)
    else $error("baudGen: ce16x high on consecutive cycles");

endmodule

// ==== logic/txFrameIf.sv ====
`timescale 1ns/10ps

interface txFrameIf;
    import uartTxPkg::*;

    logic       load;       // Capture byte and format, start bit follows
    logic       shift;      // Bit boundary strobe
    logic [7:0] data;       // Byte at the FIFO head
    fmtT        fmt;        // Frame shape for the byte being loaded
    logic       parBit;     // Parity computed by the shifter at load
    txStateT    state;      // Current FSM state, selects what the line shows

    // Controller side
    modport control (
        output load,
        output shift,
        output data,
        output fmt,
        output state,
        input  parBit
    );

    // Shift register side
    modport shifter (
        input  load,
        input  shift,
        input  data,
        input  fmt,
        input  state,
        output parBit
    );

endinterface

// ==== logic/uartTxPkg.sv ====
package uartTxPkg;

    ////////////////////////////////////////////////////////////////////
    // Frame format

    typedef struct packed {
        logic       len;        // 1 selects 7 data bits
        logic       numStop;    // 1 selects two stop bits
        logic       parEn;      // Parity bit present
        logic [1:0] par;        // One of the parity codes below
    } fmtT;

    // Parity codes carried in fmtT.par
    localparam logic [1:0] ParOdd   = 2'd0;
    localparam logic [1:0] ParEven  = 2'd1;
    localparam logic [1:0] ParSpace = 2'd2;
    localparam logic [1:0] ParMark  = 2'd3;

    ////////////////////////////////////////////////////////////////////
    // Transmit FSM states, shared by the controller and the shifter

    typedef enum logic [2:0] {
        Idle   = 3'd0,
        Start  = 3'd1,
        Shift  = 3'd2,
        Parity = 3'd3,
        Stop   = 3'd4
    } txStateT;

    // Format code to frame shape, sixteen entries
    function automatic fmtT decodeFmt(input logic [3:0] code);
        fmtT f;
        case (code)
            4'h2:    f = '{len: 1'b0, numStop: 1'b0, parEn: 1'b1, par: ParOdd};   // 8O1
            4'h3:    f = '{len: 1'b0, numStop: 1'b0, parEn: 1'b1, par: ParEven};  // 8E1
            4'h4:    f = '{len: 1'b0, numStop: 1'b0, parEn: 1'b1, par: ParSpace}; // 8S1
            4'h5:    f = '{len: 1'b0, numStop: 1'b0, parEn: 1'b1, par: ParMark};  // 8M1
            4'h7:    f = '{len: 1'b0, numStop: 1'b1, parEn: 1'b0, par: ParOdd};   // 8N2
            4'h8:    f = '{len: 1'b0, numStop: 1'b1, parEn: 1'b1, par: ParOdd};   // 8O2
            4'h9:    f = '{len: 1'b0, numStop: 1'b1, parEn: 1'b1, par: ParEven};  // 8E2
            4'hA:    f = '{len: 1'b0, numStop: 1'b1, parEn: 1'b1, par: ParSpace}; // 8S2
            4'hB:    f = '{len: 1'b0, numStop: 1'b1, parEn: 1'b1, par: ParMark};  // 8M2
            4'hC:    f = '{len: 1'b1, numStop: 1'b0, parEn: 1'b1, par: ParOdd};   // 7O1
            4'hD:    f = '{len: 1'b1, numStop: 1'b0, parEn: 1'b1, par: ParEven};  // 7E1
            4'hE:    f = '{len: 1'b1, numStop: 1'b1, parEn: 1'b1, par: ParOdd};   // 7O2
            4'hF:    f = '{len: 1'b1, numStop: 1'b1, parEn: 1'b1, par: ParEven};  // 7E2
            default: f = '{len: 1'b0, numStop: 1'b0, parEn: 1'b0, par: ParOdd};   // 8N1, codes 0 1 6
        endcase
        return f;
    endfunction

endpackage
